// File: s3g_cfg.svh
`ifndef S3G_CFG_SVH
`define S3G_CFG_SVH

// Register file sizes
`define S3G_NUM_OUT_REGS 32
`define S3G_BANK_SIZE    8
`define S3G_NUM_BANKS    4   // NUM_OUT_REGS / BANK_SIZE
`define S3G_NUM_IN_REGS  16

`define S3G_BUF_BYTES    16  // Per packet buffer
`define S3G_NUM_INTS     32

// Version reply bytes
`define S3G_VER_HI       8'hBA
`define S3G_VER_LO       8'hCE

`define S3G_EXT_VER_0    8'h02
`define S3G_EXT_VER_1    8'h00
`define S3G_EXT_VER_2    8'h02
`define S3G_EXT_VER_3    8'h00
`define S3G_EXT_VER_4    8'hCE
`define S3G_EXT_VER_5    8'h00
`define S3G_EXT_VER_6    8'h00
`define S3G_EXT_VER_7    8'h00

`endif

// File: s3g_proto_pkg.sv
`default_nettype none

package s3g_proto_pkg;

    typedef enum logic [7:0] {
        OP_VERSION       = 8'd0,
        OP_EXT_VERSION   = 8'd27,
        OP_WRITE_OUT_REG = 8'd60,
        OP_READ_IN_REG   = 8'd61,
        OP_OUT_STBS      = 8'd62,
        OP_CLEAR_INTS    = 8'd63
    } s3g_opcode_e;

    // What the reply builder has to send next
    typedef enum logic [3:0] {
        REPLY_NONE,
        REPLY_OK,
        REPLY_ERROR,
        REPLY_UNKNOWN,
        REPLY_VERSION,
        REPLY_EXT_VERSION,
        REPLY_READ_REG
    } s3g_reply_e;

    typedef enum logic [7:0] {
        CODE_ERROR   = 8'h80,
        CODE_OK      = 8'h81,
        CODE_UNKNOWN = 8'h85
    } s3g_code_e;

    typedef enum logic [2:0] {ST_IDLE, ST_READ, ST_READ1, ST_DELAY, ST_BUSY} s3g_state_e;

endpackage

`default_nettype wire

// File: s3g_regs_pkg.sv
`default_nettype none

`include "s3g_cfg.svh"

package s3g_regs_pkg;

    typedef logic [7:0] s3g_byte_t;
    typedef logic [31:0] s3g_word_t;
    typedef logic [7:0] s3g_addr_t;

    typedef s3g_byte_t s3g_buf_t [`S3G_BUF_BYTES];

    // Output register write with a one cycle strobe
    typedef struct packed {
        logic      stb;
        s3g_addr_t addr;
        s3g_word_t data;
    } s3g_out_wr_t;

endpackage

`default_nettype wire

// File: s3g_cmd_decoder.sv
`default_nettype none

`include "s3g_cfg.svh"

module s3g_cmd_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rx_packet_done,
    input  logic                          rx_packet_error,
    input  logic                          tx_busy,
    input  s3g_regs_pkg::s3g_byte_t       rx_payload_len,
    input  s3g_regs_pkg::s3g_buf_t        rx_buf,
    input  logic [`S3G_NUM_INTS-1:0]      ints,
    output s3g_regs_pkg::s3g_out_wr_t     out_wr,
    output logic [`S3G_NUM_INTS-1:0]      out_stbs,
    output logic [`S3G_NUM_INTS-1:0]      pending_ints,
    output s3g_proto_pkg::s3g_reply_e     reply_kind,
    output logic [15:0]                   cmd_id,
    output s3g_regs_pkg::s3g_byte_t       in_sel
);
    import s3g_proto_pkg::*;
    import s3g_regs_pkg::*;

    s3g_state_e state;
    s3g_state_e next_state;
    s3g_reply_e next_reply;
    s3g_opcode_e opcode;
    s3g_byte_t next_in_sel;
    s3g_word_t arg_word;
    logic [`S3G_NUM_INTS-1:0] next_stbs;
    logic [`S3G_NUM_INTS-1:0] clr_mask;
    logic start;

    assign opcode = s3g_opcode_e'(rx_buf[2]);
    assign arg_word = {rx_buf[6], rx_buf[5], rx_buf[4], rx_buf[3]};  // Little-endian
    assign start = (state == ST_IDLE) && (rx_packet_done || rx_packet_error);

    always_comb
    begin
        next_state = state;
        next_reply = REPLY_NONE;
        next_in_sel = in_sel;
        next_stbs = '0;
        clr_mask = '0;
        out_wr.stb = 1'b0;
        out_wr.addr = rx_buf[3];
        out_wr.data = {rx_buf[7], rx_buf[6], rx_buf[5], rx_buf[4]};

        case (state)
            ST_IDLE:
            begin
                if (rx_packet_done)
                begin
                    next_state = ST_DELAY;
                    if (rx_payload_len == 8'd0)
                        next_reply = REPLY_OK;  // Ping
                    else
                    begin
                        case (opcode)
                            OP_VERSION:
                                next_reply = REPLY_VERSION;
                            OP_EXT_VERSION:
                                next_reply = REPLY_EXT_VERSION;
                            OP_WRITE_OUT_REG:
                            begin
                                out_wr.stb = 1'b1;
                                next_reply = REPLY_OK;
                            end
                            OP_READ_IN_REG:
                            begin
                                next_in_sel = rx_buf[3];
                                next_state = ST_READ;
                            end
                            OP_OUT_STBS:
                            begin
                                next_stbs = arg_word;
                                next_reply = REPLY_OK;
                            end
                            OP_CLEAR_INTS:
                            begin
                                clr_mask = arg_word;
                                next_reply = REPLY_OK;
                            end
                            default:
                                next_reply = REPLY_UNKNOWN;
                        endcase
                    end
                end
                else if (rx_packet_error)
                begin
                    next_state = ST_DELAY;
                    next_reply = REPLY_ERROR;
                end
            end
            ST_READ:
                next_state = ST_READ1;  // Builder captures the input word
            ST_READ1:
            begin
                next_state = ST_DELAY;
                next_reply = REPLY_READ_REG;
            end
            ST_DELAY:
                next_state = ST_BUSY;
            ST_BUSY:
            begin
                if (!tx_busy)
                    next_state = ST_IDLE;
            end
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            reply_kind <= REPLY_NONE;
            cmd_id <= 16'hFFFF;
            in_sel <= '0;
            out_stbs <= '0;
            pending_ints <= '0;
        end
        else
        begin
            state <= next_state;
            reply_kind <= next_reply;
            in_sel <= next_in_sel;
            out_stbs <= next_stbs;
            pending_ints <= (pending_ints & ~clr_mask) | ints;  // Set wins over clear
            if (start)
                cmd_id <= {rx_buf[1], rx_buf[0]};
        end
    end

endmodule

`default_nettype wire

// File: s3g_out_bank.sv
`default_nettype none

`include "s3g_cfg.svh"

module s3g_out_bank #(
    parameter int BANK_INDEX = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  s3g_regs_pkg::s3g_out_wr_t out_wr,
    output s3g_regs_pkg::s3g_word_t   regs [`S3G_BANK_SIZE]
);
    import s3g_regs_pkg::*;

    localparam int IDX_W = $clog2(`S3G_BANK_SIZE);
    localparam int ADDR_W = $bits(s3g_addr_t);

    logic hit;

    // High address bits pick the bank, so 32 and up never match
    assign hit = out_wr.stb && (out_wr.addr[ADDR_W-1:IDX_W] == BANK_INDEX);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `S3G_BANK_SIZE; i++)
                regs[i] <= '0;
        end
        else if (hit)
            regs[out_wr.addr[IDX_W-1:0]] <= out_wr.data;
    end

endmodule

`default_nettype wire

// File: s3g_reply_builder.sv
`default_nettype none

`include "s3g_cfg.svh"

module s3g_reply_builder (
    input  logic                      clk,
    input  s3g_proto_pkg::s3g_reply_e reply_kind,
    input  logic [15:0]               cmd_id,
    input  s3g_regs_pkg::s3g_byte_t   in_sel,
    input  s3g_regs_pkg::s3g_word_t   in_regs [`S3G_NUM_IN_REGS],
    output logic                      tx_packet_wr,
    output s3g_regs_pkg::s3g_byte_t   tx_payload_len,
    output s3g_regs_pkg::s3g_buf_t    tx_buf
);
    import s3g_proto_pkg::*;
    import s3g_regs_pkg::*;

    localparam int SEL_W = $clog2(`S3G_NUM_IN_REGS);

    s3g_word_t in_data;

    always_ff @(posedge clk)
    begin
        if (in_sel < `S3G_NUM_IN_REGS)
            in_data <= in_regs[in_sel[SEL_W-1:0]];
        else
            in_data <= '0;  // No such input register
    end

    always_ff @(posedge clk)
    begin
        tx_packet_wr <= 1'b1;
        tx_payload_len <= 8'd3;
        for (int i = 0; i < `S3G_BUF_BYTES; i++)
            tx_buf[i] <= '0;
        tx_buf[0] <= cmd_id[7:0];
        tx_buf[1] <= cmd_id[15:8];

        case (reply_kind)
            REPLY_OK:
                tx_buf[2] <= CODE_OK;
            REPLY_ERROR:
                tx_buf[2] <= CODE_ERROR;
            REPLY_UNKNOWN:
                tx_buf[2] <= CODE_UNKNOWN;
            REPLY_VERSION:
            begin
                tx_payload_len <= 8'd5;
                tx_buf[2] <= CODE_OK;
                tx_buf[3] <= `S3G_VER_HI;
                tx_buf[4] <= `S3G_VER_LO;
            end
            REPLY_EXT_VERSION:
            begin
                tx_payload_len <= 8'd11;
                tx_buf[2] <= CODE_OK;
                tx_buf[3] <= `S3G_EXT_VER_0;
                tx_buf[4] <= `S3G_EXT_VER_1;
                tx_buf[5] <= `S3G_EXT_VER_2;
                tx_buf[6] <= `S3G_EXT_VER_3;
                tx_buf[7] <= `S3G_EXT_VER_4;
                tx_buf[8] <= `S3G_EXT_VER_5;
                tx_buf[9] <= `S3G_EXT_VER_6;
                tx_buf[10] <= `S3G_EXT_VER_7;
            end
            REPLY_READ_REG:
            begin
                tx_payload_len <= 8'd7;
                tx_buf[2] <= CODE_OK;
                tx_buf[3] <= in_data[7:0];  // LSB first
                tx_buf[4] <= in_data[15:8];
                tx_buf[5] <= in_data[23:16];
                tx_buf[6] <= in_data[31:24];
            end
            default:
            begin
                tx_packet_wr <= 1'b0;
                tx_payload_len <= '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: s3g_executor.sv
`default_nettype none

`include "s3g_cfg.svh"

module s3g_executor (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rx_packet_done,
    input  logic                    rx_packet_error,
    input  s3g_regs_pkg::s3g_byte_t rx_payload_len,
    input  s3g_regs_pkg::s3g_buf_t  rx_buf,
    input  logic                    tx_busy,
    output logic                    tx_packet_wr,
    output s3g_regs_pkg::s3g_byte_t tx_payload_len,
    output s3g_regs_pkg::s3g_buf_t  tx_buf,
    output s3g_regs_pkg::s3g_word_t out_regs [`S3G_NUM_OUT_REGS],
    input  s3g_regs_pkg::s3g_word_t in_regs [`S3G_NUM_IN_REGS],
    output logic [`S3G_NUM_INTS-1:0] out_stbs,
    input  logic [`S3G_NUM_INTS-1:0] ints,
    output logic [`S3G_NUM_INTS-1:0] pending_ints
);
    import s3g_proto_pkg::*;
    import s3g_regs_pkg::*;

    s3g_out_wr_t out_wr;
    s3g_reply_e reply_kind;
    logic [15:0] cmd_id;
    s3g_byte_t in_sel;

    s3g_cmd_decoder i_cmd_decoder (
        .clk            (clk),
        .rst            (rst),
        .rx_packet_done (rx_packet_done),
        .rx_packet_error(rx_packet_error),
        .tx_busy        (tx_busy),
        .rx_payload_len (rx_payload_len),
        .rx_buf         (rx_buf),
        .ints           (ints),
        .out_wr         (out_wr),
        .out_stbs       (out_stbs),
        .pending_ints   (pending_ints),
        .reply_kind     (reply_kind),
        .cmd_id         (cmd_id),
        .in_sel         (in_sel)
    );

    // Each bank drives its own slice of out_regs
    genvar g;
    generate
        for (g = 0; g < `S3G_NUM_BANKS; g++)
        begin : g_bank
            localparam int LO = g * `S3G_BANK_SIZE;
            localparam int HI = LO + `S3G_BANK_SIZE - 1;

            s3g_out_bank #(
                .BANK_INDEX(g)
            ) i_out_bank (
                .clk   (clk),
                .rst   (rst),
                .out_wr(out_wr),
                .regs  (out_regs[LO:HI])
            );
        end
    endgenerate

    s3g_reply_builder i_reply_builder (
        .clk           (clk),
        .reply_kind    (reply_kind),
        .cmd_id        (cmd_id),
        .in_sel        (in_sel),
        .in_regs       (in_regs),
        .tx_packet_wr  (tx_packet_wr),
        .tx_payload_len(tx_payload_len),
        .tx_buf        (tx_buf)
    );

endmodule

`default_nettype wire

// File: s3g_executor_tb.sv
`default_nettype none

`include "s3g_cfg.svh"

module s3g_executor_tb;
    import s3g_regs_pkg::*;

    localparam int NUM_ROWS = 16;
    localparam int MAX_BUSY = 15;  // 8 plus up to 7 random cycles
    localparam int CYCLE_LIMIT = NUM_ROWS * (MAX_BUSY + 12) + 20;

    localparam logic [2:0] CHK_NONE = 3'd0;
    localparam logic [2:0] CHK_WRITE = 3'd1;
    localparam logic [2:0] CHK_READ = 3'd2;
    localparam logic [2:0] CHK_STB = 3'd3;
    localparam logic [2:0] CHK_CLR = 3'd4;

    // One request and the reply it should get
    typedef struct packed {
        logic        err;       // Receive error instead of packet done
        logic        busy;      // Hold tx_busy high after this request
        logic [2:0]  chk;
        logic [15:0] id;
        logic [7:0]  len;
        logic [7:0]  op;
        logic [7:0]  b3;
        logic [31:0] word;      // Bytes 4 to 7
        logic [31:0] irq;       // Interrupt lines pulsed before the request
        logic [7:0]  exp_len;
        logic [7:0]  exp_code;
        logic [63:0] exp_data;  // Reply bytes 3 to 10 with byte 3 lowest
    } row_t;

    logic clk;
    logic rst;
    logic rx_packet_done;
    logic rx_packet_error;
    s3g_byte_t rx_payload_len;
    s3g_buf_t rx_buf;
    logic tx_busy;
    logic tx_packet_wr;
    s3g_byte_t tx_payload_len;
    s3g_buf_t tx_buf;
    s3g_word_t out_regs [`S3G_NUM_OUT_REGS];
    s3g_word_t in_regs [`S3G_NUM_IN_REGS];
    logic [`S3G_NUM_INTS-1:0] out_stbs;
    logic [`S3G_NUM_INTS-1:0] ints;
    logic [`S3G_NUM_INTS-1:0] pending_ints;

    row_t rows [NUM_ROWS];
    string row_name [NUM_ROWS];
    s3g_word_t out_model [`S3G_NUM_OUT_REGS];
    logic [31:0] pend_model;
    int seed = 95015;
    int cycles;
    int busy_left;

    s3g_executor i_s3g_executor (
        .clk            (clk),
        .rst            (rst),
        .rx_packet_done (rx_packet_done),
        .rx_packet_error(rx_packet_error),
        .rx_payload_len (rx_payload_len),
        .rx_buf         (rx_buf),
        .tx_busy        (tx_busy),
        .tx_packet_wr   (tx_packet_wr),
        .tx_payload_len (tx_payload_len),
        .tx_buf         (tx_buf),
        .out_regs       (out_regs),
        .in_regs        (in_regs),
        .out_stbs       (out_stbs),
        .ints           (ints),
        .pending_ints   (pending_ints)
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Testbench stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
            stop_run($sformatf("ERROR %s expected %0h actual %0h", name, expected, actual));
    endtask

    // One clock edge with the tx_busy countdown and the timeout
    task automatic step_edge;
        @(posedge clk);
        if (busy_left > 0)
            busy_left--;
        tx_busy <= (busy_left > 0);
        cycles++;
        if (cycles > CYCLE_LIMIT)
            stop_run("Timeout: the run went past its cycle limit without a reply");
    endtask

    task load_table;
        // err   busy  chk        id        len   op     b3     word
        // irq   exp_len exp_code exp_data
        rows[0] = '{1'b0, 1'b0, CHK_NONE, 16'h0101, 8'd0, 8'h00, 8'h00, 32'h0,
                    32'h0, 8'd3, 8'h81, 64'h0};
        rows[1] = '{1'b1, 1'b0, CHK_NONE, 16'h0202, 8'd4, 8'h3C, 8'h02, 32'h1234,
                    32'h0, 8'd3, 8'h80, 64'h0};
        rows[2] = '{1'b0, 1'b0, CHK_NONE, 16'h0303, 8'd1, 8'h07, 8'h00, 32'h0,
                    32'h0, 8'd3, 8'h85, 64'h0};
        rows[3] = '{1'b0, 1'b0, CHK_NONE, 16'h0404, 8'd1, 8'h00, 8'h00, 32'h0,
                    32'h0, 8'd5, 8'h81, 64'h0000_0000_0000_CEBA};
        rows[4] = '{1'b0, 1'b0, CHK_NONE, 16'h0505, 8'd1, 8'h1B, 8'h00, 32'h0,
                    32'h0, 8'd11, 8'h81, 64'h0000_00CE_0002_0002};
        rows[5] = '{1'b0, 1'b0, CHK_WRITE, 16'h0606, 8'd6, 8'h3C, 8'd5, 32'hDEAD_BEEF,
                    32'h0, 8'd3, 8'h81, 64'h0};
        rows[6] = '{1'b0, 1'b0, CHK_WRITE, 16'h0707, 8'd6, 8'h3C, 8'd31, 32'h1357_9BDF,
                    32'h0, 8'd3, 8'h81, 64'h0};
        rows[7] = '{1'b0, 1'b0, CHK_WRITE, 16'h0808, 8'd6, 8'h3C, 8'd40, 32'hFFFF_FFFF,
                    32'h0, 8'd3, 8'h81, 64'h0};
        rows[8] = '{1'b0, 1'b0, CHK_READ, 16'h0909, 8'd2, 8'h3D, 8'd3, 32'h0,
                    32'h0, 8'd7, 8'h81, 64'h0};
        rows[9] = '{1'b0, 1'b0, CHK_READ, 16'h0A0A, 8'd2, 8'h3D, 8'd20, 32'h0,
                    32'h0, 8'd7, 8'h81, 64'h0};
        rows[10] = '{1'b0, 1'b0, CHK_STB, 16'h0B0B, 8'd5, 8'h3E, 8'h40, 32'h0080_0102,
                     32'h0, 8'd3, 8'h81, 64'h0};
        rows[11] = '{1'b0, 1'b0, CHK_CLR, 16'h0C0C, 8'd5, 8'h3F, 8'h31, 32'h0,
                     32'h8000_00F1, 8'd3, 8'h81, 64'h0};
        rows[12] = '{1'b0, 1'b1, CHK_NONE, 16'h0D0D, 8'd0, 8'h00, 8'h00, 32'h0,
                     32'h0, 8'd3, 8'h81, 64'h0};
        rows[13] = '{1'b0, 1'b0, CHK_READ, 16'h0E0E, 8'd2, 8'h3D, 8'd15, 32'h0,
                     32'h0, 8'd7, 8'h81, 64'h0};
        rows[14] = '{1'b0, 1'b1, CHK_WRITE, 16'h0F0F, 8'd6, 8'h3C, 8'd8, 32'hA5A5_0F0F,
                     32'h0, 8'd3, 8'h81, 64'h0};
        rows[15] = '{1'b0, 1'b0, CHK_NONE, 16'h1010, 8'd1, 8'h00, 8'h00, 32'h0,
                     32'h0, 8'd5, 8'h81, 64'h0000_0000_0000_CEBA};
        row_name = '{"ping", "rx error", "unknown opcode", "version", "ext version",
                     "write reg 5", "write reg 31", "write reg 40", "read reg 3",
                     "read reg 20", "strobes", "clear ints", "ping then tx busy",
                     "read reg 15 after busy", "write reg 8 then tx busy",
                     "version after busy"};
    endtask

    initial
    begin
        row_t cur;
        string name;
        logic blocked;
        logic got;
        int stb_cycles;
        logic [31:0] stb_seen;
        logic [31:0] mask;
        logic [63:0] exp_data;
        s3g_byte_t exp_byte;

        clk = 1'b0;
        rst = 1'b1;
        rx_packet_done = 1'b0;
        rx_packet_error = 1'b0;
        rx_payload_len = '0;
        tx_busy = 1'b0;
        ints = '0;
        for (int i = 0; i < `S3G_BUF_BYTES; i++)
            rx_buf[i] = '0;
        for (int k = 0; k < `S3G_NUM_IN_REGS; k++)
            in_regs[k] = $random(seed);
        for (int a = 0; a < `S3G_NUM_OUT_REGS; a++)
            out_model[a] = '0;
        pend_model = '0;
        cycles = 0;
        busy_left = 0;
        load_table();

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset tx_packet_wr", 0, tx_packet_wr);
        check_value("reset out_stbs", 0, out_stbs);
        check_value("reset pending_ints", 0, pending_ints);
        for (int a = 0; a < `S3G_NUM_OUT_REGS; a++)
            check_value($sformatf("reset out_regs[%0d]", a), 0, out_regs[a]);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            cur = rows[r];
            name = row_name[r];
            mask = {cur.word[23:0], cur.b3};  // Bytes 3 to 6 in little-endian order

            if (cur.irq != '0)
            begin
                step_edge();
                ints <= cur.irq;
                pend_model = pend_model | cur.irq;
            end

            step_edge();
            blocked = (busy_left > 0);  // Previous reply still holds the transmitter
            ints <= '0;
            rx_packet_done <= !cur.err;
            rx_packet_error <= cur.err;
            rx_payload_len <= cur.len;
            for (int i = 0; i < `S3G_BUF_BYTES; i++)
                rx_buf[i] <= 8'h00;
            rx_buf[0] <= cur.id[7:0];
            rx_buf[1] <= cur.id[15:8];
            rx_buf[2] <= cur.op;
            rx_buf[3] <= cur.b3;
            rx_buf[4] <= cur.word[7:0];
            rx_buf[5] <= cur.word[15:8];
            rx_buf[6] <= cur.word[23:16];
            rx_buf[7] <= cur.word[31:24];
            if (cur.busy)
            begin
                busy_left = 8 + ($random(seed) & 7);
                tx_busy <= 1'b1;
            end
            @(negedge clk);
            check_value($sformatf("%s pending before", name), pend_model, pending_ints);

            // Packet strobe stays up until the reply shows it was taken
            got = 1'b0;
            stb_cycles = 0;
            stb_seen = '0;
            while (!got)
            begin
                step_edge();
                @(negedge clk);
                if (out_stbs != '0)
                begin
                    stb_cycles++;
                    stb_seen = out_stbs;
                end
                got = tx_packet_wr;
            end

            if (blocked)
                check_value($sformatf("%s tx_busy at reply", name), 0, tx_busy);
            exp_data = cur.exp_data;
            if (cur.chk == CHK_READ)
                exp_data = (cur.b3 < 8'd16) ? {32'h0, in_regs[cur.b3[3:0]]} : 64'h0;
            check_value($sformatf("%s payload length", name), cur.exp_len, tx_payload_len);
            for (int i = 0; i < `S3G_BUF_BYTES; i++)
            begin
                if (i == 0)
                    exp_byte = cur.id[7:0];
                else if (i == 1)
                    exp_byte = cur.id[15:8];
                else if (i == 2)
                    exp_byte = cur.exp_code;
                else if (i < 11)
                    exp_byte = exp_data[8*(i-3) +: 8];
                else
                    exp_byte = 8'h00;
                check_value($sformatf("%s tx_buf[%0d]", name, i), exp_byte, tx_buf[i]);
            end

            step_edge();
            rx_packet_done <= 1'b0;
            rx_packet_error <= 1'b0;
            @(negedge clk);
            check_value($sformatf("%s single reply", name), 0, tx_packet_wr);

            if (cur.chk == CHK_WRITE && cur.b3 < 8'd32)
                out_model[cur.b3[4:0]] = cur.word;
            for (int a = 0; a < `S3G_NUM_OUT_REGS; a++)
                check_value($sformatf("%s out_regs[%0d]", name, a), out_model[a], out_regs[a]);

            check_value($sformatf("%s strobe cycles", name), (cur.chk == CHK_STB), stb_cycles);
            if (cur.chk == CHK_STB)
                check_value($sformatf("%s strobe mask", name), mask, stb_seen);

            if (cur.chk == CHK_CLR)
                pend_model = pend_model & ~mask;
            check_value($sformatf("%s pending after", name), pend_model, pending_ints);
        end

        // Nothing may follow the last reply
        repeat (5)
        begin
            step_edge();
            @(negedge clk);
            check_value("idle after last row", 0, tx_packet_wr);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: s3g_executor.f
+incdir+.
s3g_proto_pkg.sv
s3g_regs_pkg.sv
s3g_cmd_decoder.sv
s3g_out_bank.sv
s3g_reply_builder.sv
s3g_executor.sv
s3g_executor_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module s3g_executor_tb \
    -f s3g_executor.f \
    --Mdir obj_dir -o s3g_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/s3g_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit 1
fi

echo "Simulation finished"
exit 0
